/* design/mac_consts.svh */
`ifndef MAC_CONSTS_SVH
`define MAC_CONSTS_SVH

// Row geometry, valid for 1 to 8 elements
`define MAC_NUM_PE 4

// Lane widths, product bits plus 8 bits of headroom
`define MAC_LANE8_W 24
`define MAC_LANE4_W 16
`define MAC_ACC_W 64

// Multiplier latency in cycles
`define MAC_MULT_STAGES 2

// APB byte addresses
`define MAC_ADDR_CTRL 8'h00
`define MAC_ADDR_PIXEL 8'h04
`define MAC_ADDR_STEP 8'h08
`define MAC_ADDR_STATUS 8'h0C
`define MAC_ADDR_WEIGHT_BASE 8'h10
`define MAC_ADDR_ACC_BASE 8'h40

`endif

/* design/mac_pkg.sv */
`include "mac_consts.svh"

package mac_pkg;

  // Operating mode of the packed multiplier
  typedef enum logic {
    MODE_8X8 = 1'b0,
    MODE_4X4 = 1'b1
  } mac_mode_t;

  // Command shared by every element of the row
  typedef struct packed {
    logic            step;
    logic            clear;
    mac_mode_t       mode;
    // Index 0 is p0, index 1 is p1
    logic [1:0][7:0] pixel;
  } mac_cmd_t;

  // One accumulator word
  // Mode 0 uses two 24-bit lanes, mode 1 four 16-bit lanes
  typedef logic [`MAC_ACC_W-1:0] mac_acc_t;

endpackage

/* design/apb_pkg.sv */
package apb_pkg;

  // Master to slave
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // Slave to master
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

/* design/packed_mult.sv */
`timescale 1ns/1ps

module packed_mult (
  input  logic               clk,
  input  logic               reset,
  input  logic        [23:0] a,
  input  logic signed [17:0] b,
  output logic signed [41:0] p
);

  logic        [23:0] a_q;
  logic signed [17:0] b_q;
  logic signed [41:0] prod;

  // Unsigned a gets a zero sign bit so the multiply stays signed
  // Full product range fits in 42 bits
  assign prod = $signed({1'b0, a_q}) * b_q;

  // Input register then product register as in a DSP slice
  always_ff @(posedge clk) begin
    if (reset) begin
      a_q <= '0;
      b_q <= '0;
      p   <= '0;
    end else begin
      a_q <= a;
      b_q <= b;
      p   <= prod;
    end
  end

  a_p_known: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(p)
  );

endmodule

/* design/packed_mac_pe.sv */
`timescale 1ns/1ps
`include "mac_consts.svh"

module packed_mac_pe import mac_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  mac_cmd_t    cmd,
  input  logic [15:0] weight,
  output mac_acc_t    acc,
  output logic        busy
);

  localparam int STAGES = `MAC_MULT_STAGES;
  localparam int L8     = `MAC_LANE8_W;
  localparam int L4     = `MAC_LANE4_W;

  logic        [23:0]  op_a;
  logic signed [17:0]  op_b;
  logic signed [41:0]  prod;
  logic [STAGES-1:0]   step_sr;
  mac_mode_t           mode_sr [STAGES];
  logic [15:0]         f8 [2];
  logic [7:0]          f4 [4];

  ////////////////////////////////////////////////////////////////////////////
  // Operand packing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (cmd.mode == MODE_8X8) begin
      // p1 sits 16 bits above p0, one shared weight
      op_a = {cmd.pixel[1], 8'h00, cmd.pixel[0]};
      op_b = {{10{weight[7]}}, weight[7:0]};
    end else begin
      op_a = {4'h0, cmd.pixel[1][3:0], 12'h000, cmd.pixel[0][3:0]};
      // w1 at 8 bits above w0, summed so a negative w0 borrows from w1
      op_b = {{6{weight[11]}}, weight[11:8], 8'h00} + {{14{weight[3]}}, weight[3:0]};
    end
  end

  packed_mult u_mult (
    .clk   (clk),
    .reset (reset),
    .a     (op_a),
    .b     (op_b),
    .p     (prod)
  );

  // Step and mode follow the product down the pipe
  always_ff @(posedge clk) begin
    if (reset) begin
      step_sr <= '0;
    end else begin
      step_sr[0] <= cmd.step;
      for (int i = 1; i < STAGES; i++) begin
        step_sr[i] <= step_sr[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    mode_sr[0] <= cmd.mode;
    for (int i = 1; i < STAGES; i++) begin
      mode_sr[i] <= mode_sr[i-1];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Field extraction with borrow correction
  ////////////////////////////////////////////////////////////////////////////

  // Each field takes back the borrow of the negative field below it
  assign f8[0] = prod[15:0];
  assign f8[1] = prod[31:16] + {15'h0000, prod[15]};

  assign f4[0] = prod[7:0];
  assign f4[1] = prod[15:8] + {7'h00, prod[7]};
  assign f4[2] = prod[23:16] + {7'h00, prod[15]};
  assign f4[3] = prod[31:24] + {7'h00, prod[23]};

  // Lanes wrap on overflow
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (cmd.clear) begin
      acc <= '0;
    end else if (step_sr[STAGES-1]) begin
      if (mode_sr[STAGES-1] == MODE_8X8) begin
        for (int i = 0; i < 2; i++) begin
          acc[i*L8 +: L8] <= acc[i*L8 +: L8] + {{(L8-16){f8[i][15]}}, f8[i]};
        end
      end else begin
        for (int i = 0; i < 4; i++) begin
          acc[i*L4 +: L4] <= acc[i*L4 +: L4] + {{(L4-8){f4[i][7]}}, f4[i]};
        end
      end
    end
  end

  // Busy from the pulse until the lane update lands
  assign busy = cmd.step | (|step_sr);

  a_mode_stable: assert property (
    @(posedge clk) disable iff (reset) (|step_sr) |-> $stable(cmd.mode)
  );

endmodule

/* design/mac_row.sv */
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_row import mac_pkg::*; (
  input  logic                             clk,
  input  logic                             reset,
  input  mac_cmd_t                         cmd,
  input  logic [`MAC_NUM_PE-1:0][15:0]     weights,
  output mac_acc_t [`MAC_NUM_PE-1:0]       accs,
  output logic                             busy
);

  logic [`MAC_NUM_PE-1:0] pe_busy;

  // Same pixel pair and command everywhere with one weight pair per element
  for (genvar k = 0; k < `MAC_NUM_PE; k++) begin : g_pe
    packed_mac_pe u_pe (
      .clk    (clk),
      .reset  (reset),
      .cmd    (cmd),
      .weight (weights[k]),
      .acc    (accs[k]),
      .busy   (pe_busy[k])
    );
  end

  // Row busy while any element has a step in flight
  assign busy = |pe_busy;

endmodule

/* design/apb_mac_regs.sv */
`timescale 1ns/1ps
`include "mac_consts.svh"

module apb_mac_regs import mac_pkg::*, apb_pkg::*; (
  input  logic                         clk,
  input  logic                         reset,
  input  apb_req_t                     apb_req,
  output apb_rsp_t                     apb_rsp,
  output mac_cmd_t                     cmd,
  output logic [`MAC_NUM_PE-1:0][15:0] weights,
  input  mac_acc_t [`MAC_NUM_PE-1:0]   accs,
  input  logic                         busy
);

  localparam logic [7:0] WEIGHT_END = `MAC_ADDR_WEIGHT_BASE + 4 * `MAC_NUM_PE;
  localparam logic [7:0] ACC_END    = `MAC_ADDR_ACC_BASE + 8 * `MAC_NUM_PE;

  logic            access, wr, rd;
  logic            hit_ctrl, hit_pixel, hit_step, hit_status, hit_weight, hit_acc;
  logic            mapped, err;
  logic [7:0]      w_off, a_off;
  logic [2:0]      w_idx, a_idx;
  mac_acc_t        acc_sel;
  mac_mode_t       mode_q;
  logic [1:0][7:0] pixel_q;
  logic            step_q, clear_q;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  // Zero wait states, so the access phase is the only active cycle
  assign access = apb_req.psel & apb_req.penable;
  assign wr     = access & apb_req.pwrite;
  assign rd     = access & ~apb_req.pwrite;

  assign hit_ctrl   = apb_req.paddr == `MAC_ADDR_CTRL;
  assign hit_pixel  = apb_req.paddr == `MAC_ADDR_PIXEL;
  assign hit_step   = apb_req.paddr == `MAC_ADDR_STEP;
  assign hit_status = apb_req.paddr == `MAC_ADDR_STATUS;
  assign hit_weight = apb_req.paddr >= `MAC_ADDR_WEIGHT_BASE && apb_req.paddr < WEIGHT_END
                      && apb_req.paddr[1:0] == 2'b00;
  assign hit_acc    = apb_req.paddr >= `MAC_ADDR_ACC_BASE && apb_req.paddr < ACC_END
                      && apb_req.paddr[1:0] == 2'b00;

  assign w_off = apb_req.paddr - `MAC_ADDR_WEIGHT_BASE;
  assign a_off = apb_req.paddr - `MAC_ADDR_ACC_BASE;
  assign w_idx = w_off[4:2];
  assign a_idx = a_off[5:3];

  assign mapped = hit_ctrl | hit_pixel | hit_step | hit_status | hit_weight | hit_acc;
  // Status and accumulators are read only
  assign err    = ~mapped | (apb_req.pwrite & (hit_status | hit_acc));

  ////////////////////////////////////////////////////////////////////////////
  // Stored configuration and pulses
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mode_q  <= MODE_8X8;
      pixel_q <= '0;
      weights <= '0;
      step_q  <= 1'b0;
      clear_q <= 1'b0;
    end else begin
      // Pulses last one cycle
      step_q  <= wr & hit_step;
      clear_q <= wr & hit_ctrl & apb_req.pwdata[1];
      if (wr && hit_ctrl) begin
        mode_q <= mac_mode_t'(apb_req.pwdata[0]);
      end
      if (wr && hit_pixel) begin
        pixel_q <= apb_req.pwdata[15:0];
      end
      if (wr && hit_weight) begin
        weights[w_idx] <= apb_req.pwdata[15:0];
      end
    end
  end

  assign cmd.step  = step_q;
  assign cmd.clear = clear_q;
  assign cmd.mode  = mode_q;
  assign cmd.pixel = pixel_q;

  ////////////////////////////////////////////////////////////////////////////
  // Read mux and response
  ////////////////////////////////////////////////////////////////////////////

  assign acc_sel = accs[a_idx];

  always_comb begin
    apb_rsp.prdata = '0;
    if (rd) begin
      if (hit_ctrl) begin
        apb_rsp.prdata = {31'h0, mode_q};
      end else if (hit_pixel) begin
        apb_rsp.prdata = {16'h0000, pixel_q};
      end else if (hit_status) begin
        apb_rsp.prdata = {31'h0, busy};
      end else if (hit_weight) begin
        apb_rsp.prdata = {16'h0000, weights[w_idx]};
      end else if (hit_acc) begin
        // Low word first, high word at +4
        apb_rsp.prdata = a_off[2] ? acc_sel[63:32] : acc_sel[31:0];
      end
    end
  end

  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access & err;

  a_apb_setup: assert property (
    @(posedge clk) disable iff (reset)
    apb_req.penable |-> $past(apb_req.psel && !apb_req.penable)
  );

endmodule

/* design/mac_row_top.sv */
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_row_top import mac_pkg::*, apb_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  mac_cmd_t                         cmd;
  logic [`MAC_NUM_PE-1:0][15:0]     weights;
  mac_acc_t [`MAC_NUM_PE-1:0]       accs;
  logic                             busy;

  // Register file on the APB side
  apb_mac_regs u_regs (
    .clk     (clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .cmd     (cmd),
    .weights (weights),
    .accs    (accs),
    .busy    (busy)
  );

  // Row of packed MAC elements
  mac_row u_row (
    .clk     (clk),
    .reset   (reset),
    .cmd     (cmd),
    .weights (weights),
    .accs    (accs),
    .busy    (busy)
  );

endmodule

/* verif/mac_row_tb.sv */
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_row_tb import mac_pkg::*, apb_pkg::*; ();

  localparam int NPE = `MAC_NUM_PE;
  localparam int L8  = `MAC_LANE8_W;
  localparam int L4  = `MAC_LANE4_W;

  // One table row with its expected accumulators
  typedef struct packed {
    logic                 clr;
    mac_mode_t            mode;
    logic [7:0]           p0;
    logic [7:0]           p1;
    logic [NPE-1:0][15:0] w;
    mac_acc_t [NPE-1:0]   exp;
  } row_t;

  logic     clk;
  logic     reset;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  row_t     rows[$];
  mac_acc_t model[NPE];
  int       errors;
  int       watchdog_cycles;

  mac_row_top u_dut (
    .clk     (clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model of the lane rule
  ////////////////////////////////////////////////////////////////////////////

  function automatic mac_acc_t lane_step(mac_acc_t acc, mac_mode_t mode, logic [7:0] p0,
                                         logic [7:0] p1, logic [15:0] w);
    int            pix[2];
    int            wt[2];
    logic [L8-1:0] d8;
    logic [L4-1:0] d4;
    mac_acc_t      r;
    r = acc;
    pix[0] = p0;
    pix[1] = p1;
    if (mode == MODE_8X8) begin
      wt[0] = $signed(w[7:0]);
      for (int i = 0; i < 2; i++) begin
        d8 = pix[i] * wt[0];
        r[i*L8 +: L8] = r[i*L8 +: L8] + d8;
      end
    end else begin
      wt[0] = $signed(w[3:0]);
      wt[1] = $signed(w[11:8]);
      // Lane order p0w0, p0w1, p1w0, p1w1
      for (int i = 0; i < 4; i++) begin
        d4 = (pix[i/2] % 16) * wt[i%2];
        r[i*L4 +: L4] = r[i*L4 +: L4] + d4;
      end
    end
    return r;
  endfunction

  task automatic add_row(input mac_mode_t mode, input logic clr, input logic [7:0] p0,
                         input logic [7:0] p1, input logic [NPE-1:0][15:0] w);
    row_t r;
    r.clr  = clr;
    r.mode = mode;
    r.p0   = p0;
    r.p1   = p1;
    r.w    = w;
    for (int k = 0; k < NPE; k++) begin
      if (clr) model[k] = '0;
      model[k] = lane_step(model[k], mode, p0, p1, w[k]);
      r.exp[k] = model[k];
    end
    rows.push_back(r);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB transfers and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected 0x%016h, actual 0x%016h", name, exp, act);
    end
  endtask

  // Setup and access phase with the response sampled at the closing rising edge
  task automatic bus_xfer(input string name, input logic wr, input logic [7:0] addr,
                          input logic [31:0] wdata, input logic exp_err,
                          output logic [31:0] rdata);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(posedge clk);
    rdata = apb_rsp.prdata;
    check_value($sformatf("%s pready at 0x%02h", name, addr), 1'b1, apb_rsp.pready);
    check_value($sformatf("%s pslverr at 0x%02h", name, addr), exp_err, apb_rsp.pslverr);
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic check_accs(input string name, input mac_acc_t [NPE-1:0] exp);
    logic [31:0] lo;
    logic [31:0] hi;
    for (int k = 0; k < NPE; k++) begin
      bus_xfer(name, 1'b0, `MAC_ADDR_ACC_BASE + 8 * k, '0, 1'b0, lo);
      bus_xfer(name, 1'b0, `MAC_ADDR_ACC_BASE + 8 * k + 4, '0, 1'b0, hi);
      check_value($sformatf("%s acc%0d", name, k), exp[k], {hi, lo});
    end
  endtask

  initial begin
    logic [31:0]          rd;
    logic [7:0]           pa;
    logic [7:0]           pb;
    logic [NPE-1:0][15:0] w;
    int unsigned          seed;
    string                name;
    row_t                 r;
    seed = 32'h72a6_ea06;
    void'($urandom(seed));
    errors          = 0;
    watchdog_cycles = 0;
    apb_req         = '0;
    reset           = 1'b1;
    for (int k = 0; k < NPE; k++) model[k] = '0;

    // Mode 0 with negative weights and full-scale pixels
    add_row(MODE_8X8, 1'b1, 8'd255, 8'd255, {16'h0001, 16'h007F, 16'h00FF, 16'h0080});
    add_row(MODE_8X8, 1'b0, 8'd17, 8'd255, {16'h12FE, 16'h0002, 16'h0080, 16'hA5C3});
    add_row(MODE_8X8, 1'b0, 8'd0, 8'd200, {16'h0081, 16'h00FF, 16'h0040, 16'h0011});
    add_row(MODE_8X8, 1'b0, 8'd255, 8'd1, {16'h00FF, 16'h0080, 16'h7F7F, 16'h00FF});
    // Mode 1 with weights of -8 and junk in the upper nibbles
    add_row(MODE_4X4, 1'b1, 8'hFF, 8'h09, {16'h0808, 16'hA5F8, 16'h0707, 16'h0381});
    add_row(MODE_4X4, 1'b0, 8'hF7, 8'h3F, {16'h0F0F, 16'h0108, 16'hC8E7, 16'h0800});
    add_row(MODE_4X4, 1'b0, 8'h0F, 8'h00, {16'h0808, 16'h0808, 16'h0808, 16'h0808});
    add_row(MODE_4X4, 1'b0, 8'h0A, 8'hF5, {16'h0C04, 16'h0906, 16'h0B02, 16'h0E0D});
    for (int i = 0; i < 24; i++) begin
      for (int k = 0; k < NPE; k++) w[k] = $urandom;
      add_row(mac_mode_t'($urandom % 2), 1'b1, $urandom, $urandom, w);
    end
    // Near full-scale runs long enough that every lane wraps
    for (int i = 0; i < 300; i++) begin
      for (int k = 0; k < NPE; k++) begin
        w[k] = $urandom;
        w[k][7:0] = (k % 2) ? (8'h78 | w[k][2:0]) : (8'h80 | w[k][2:0]);
      end
      pa = $urandom;
      pb = $urandom;
      add_row(MODE_8X8, i == 0, pa | 8'hF8, pb | 8'hF8, w);
    end
    for (int i = 0; i < 300; i++) begin
      for (int k = 0; k < NPE; k++) begin
        w[k] = $urandom;
        if (k % 2 == 0) w[k] = {w[k][15:12], 4'h8, w[k][7:4], 4'h8};
      end
      pa = $urandom;
      pb = $urandom;
      add_row(MODE_4X4, i == 0, pa | 8'h0F, pb | 8'h0F, w);
    end
    watchdog_cycles = rows.size() * 200;

    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    bus_xfer("reset ctrl", 1'b0, `MAC_ADDR_CTRL, '0, 1'b0, rd);
    check_value("reset ctrl", 64'h0, rd);
    bus_xfer("reset status", 1'b0, `MAC_ADDR_STATUS, '0, 1'b0, rd);
    check_value("reset status", 64'h0, rd);
    check_accs("reset", '0);

    foreach (rows[i]) begin
      r    = rows[i];
      name = $sformatf("row %0d", i);
      bus_xfer(name, 1'b1, `MAC_ADDR_CTRL, {30'h0, r.clr, r.mode}, 1'b0, rd);
      bus_xfer(name, 1'b1, `MAC_ADDR_PIXEL, {16'h0000, r.p1, r.p0}, 1'b0, rd);
      for (int k = 0; k < NPE; k++) begin
        bus_xfer(name, 1'b1, `MAC_ADDR_WEIGHT_BASE + 4 * k, {16'h0000, r.w[k]}, 1'b0, rd);
      end
      bus_xfer(name, 1'b1, `MAC_ADDR_STEP, '0, 1'b0, rd);
      // First poll lands before the lanes update
      bus_xfer(name, 1'b0, `MAC_ADDR_STATUS, '0, 1'b0, rd);
      check_value($sformatf("%s busy after step", name), 64'h1, rd[0]);
      while (rd[0]) begin
        bus_xfer(name, 1'b0, `MAC_ADDR_STATUS, '0, 1'b0, rd);
      end
      check_accs(name, r.exp);
    end

    // Bad accesses flag pslverr and leave the registers alone
    bus_xfer("err setup", 1'b1, `MAC_ADDR_PIXEL, 32'h0000_5AC3, 1'b0, rd);
    bus_xfer("err unmapped read", 1'b0, 8'h30, '0, 1'b1, rd);
    bus_xfer("err misaligned write", 1'b1, 8'h11, 32'hFFFF_FFFE, 1'b1, rd);
    bus_xfer("err status write", 1'b1, `MAC_ADDR_STATUS, 32'hFFFF_FFFE, 1'b1, rd);
    bus_xfer("err acc write", 1'b1, `MAC_ADDR_ACC_BASE, 32'hFFFF_FFFE, 1'b1, rd);
    bus_xfer("err pixel kept", 1'b0, `MAC_ADDR_PIXEL, '0, 1'b0, rd);
    check_value("err pixel kept", 64'h5AC3, rd);
    bus_xfer("err ctrl kept", 1'b0, `MAC_ADDR_CTRL, '0, 1'b0, rd);
    check_value("err ctrl kept", r.mode, rd);
    bus_xfer("err weight kept", 1'b0, `MAC_ADDR_WEIGHT_BASE, '0, 1'b0, rd);
    check_value("err weight kept", r.w[0], rd);
    check_accs("err accs kept", r.exp);

    $display("Errors: %0d failed checks over %0d table rows", errors, rows.size());
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // 200 cycles per table row
  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout after %0d cycles with the table unfinished, %0d errors so far",
             watchdog_cycles, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* src.f */
+incdir+design
design/mac_pkg.sv
design/apb_pkg.sv
design/packed_mult.sv
design/packed_mac_pe.sv
design/mac_row.sv
design/apb_mac_regs.sv
design/mac_row_top.sv
verif/mac_row_tb.sv
